// File: mips_pkg.sv
`default_nettype none

package mips_pkg;

    // Machine word and register index widths
    parameter int WORD_W     = 32;
    parameter int REG_ADDR_W = 5;

    // Register that is shown on the register_v0 port
    parameter int REG_V0 = 2;

    // Fetching from this address stops the processor
    parameter logic [WORD_W-1:0] HALT_ADDR = '0;

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [REG_ADDR_W-1:0] reg_idx_t;

    // Primary opcodes in bits 31:26
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDIU = 6'h09,
        OP_SLTI  = 6'h0a,
        OP_SLTIU = 6'h0b,
        OP_ANDI  = 6'h0c,
        OP_ORI   = 6'h0d,
        OP_XORI  = 6'h0e,
        OP_LUI   = 6'h0f,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcode_t;

    // R-type function codes in bits 5:0
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_SRA  = 6'h03,
        FN_JR   = 6'h08,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_SLT  = 6'h2a,
        FN_SLTU = 6'h2b
    } funct_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_t;

    typedef enum logic [1:0] {
        FETCH,
        EXEC,
        MEM,
        HALTED
    } cpu_state_t;

    // Everything the sequencer and datapath need from one instruction
    typedef struct packed {
        reg_idx_t rs;
        reg_idx_t rt;
        reg_idx_t dest;
        logic [4:0] shamt;
        word_t imm;
        logic [25:0] jidx;
        alu_op_t alu_op;
        logic use_imm;
        logic reg_write;
        logic is_load;
        logic is_store;
        logic is_beq;
        logic is_bne;
        logic is_j;
        logic is_jr;
    } decoded_t;

    // One Avalon transfer as seen by the master
    typedef struct packed {
        word_t addr;
        word_t wdata;
        logic read;
        logic write;
    } bus_req_t;

endpackage

`default_nettype wire

// File: mips_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module mips_decoder import mips_pkg::*; (
    input  word_t    instr,
    output decoded_t dec
);

    opcode_t op;
    funct_t  fn;

    assign op = opcode_t'(instr[31:26]);
    assign fn = funct_t'(instr[5:0]);

    always_comb begin
        // Raw fields, I-type destination by default
        dec           = '0;
        dec.rs        = instr[25:21];
        dec.rt        = instr[20:16];
        dec.dest      = instr[20:16];
        dec.shamt     = instr[10:6];
        dec.imm       = {{(WORD_W-16){instr[15]}}, instr[15:0]};
        dec.jidx      = instr[25:0];
        dec.alu_op    = ALU_ADD;
        case (op)
            OP_RTYPE: begin
                dec.dest      = instr[15:11];
                dec.reg_write = 1'b1;
                case (fn)
                    FN_ADDU: dec.alu_op = ALU_ADD;
                    FN_SUBU: dec.alu_op = ALU_SUB;
                    FN_AND:  dec.alu_op = ALU_AND;
                    FN_OR:   dec.alu_op = ALU_OR;
                    FN_XOR:  dec.alu_op = ALU_XOR;
                    FN_SLT:  dec.alu_op = ALU_SLT;
                    FN_SLTU: dec.alu_op = ALU_SLTU;
                    FN_SLL:  dec.alu_op = ALU_SLL;
                    FN_SRL:  dec.alu_op = ALU_SRL;
                    FN_SRA:  dec.alu_op = ALU_SRA;
                    FN_JR: begin
                        dec.reg_write = 1'b0;
                        dec.is_jr     = 1'b1;
                    end
                    // Unknown function code does nothing
                    default: dec.reg_write = 1'b0;
                endcase
            end
            OP_ADDIU: begin
                dec.use_imm   = 1'b1;
                dec.reg_write = 1'b1;
            end
            // Logic immediates are zero-extended
            OP_ANDI, OP_ORI, OP_XORI: begin
                dec.imm       = {{(WORD_W-16){1'b0}}, instr[15:0]};
                dec.use_imm   = 1'b1;
                dec.reg_write = 1'b1;
                dec.alu_op    = (op == OP_ANDI) ? ALU_AND :
                                (op == OP_ORI)  ? ALU_OR  : ALU_XOR;
            end
            OP_LUI: begin
                dec.use_imm   = 1'b1;
                dec.reg_write = 1'b1;
                dec.alu_op    = ALU_LUI;
            end
            OP_SLTI, OP_SLTIU: begin
                dec.use_imm   = 1'b1;
                dec.reg_write = 1'b1;
                dec.alu_op    = (op == OP_SLTI) ? ALU_SLT : ALU_SLTU;
            end
            OP_BEQ: dec.is_beq = 1'b1;
            OP_BNE: dec.is_bne = 1'b1;
            OP_J:   dec.is_j   = 1'b1;
            // Load writes rt later, from the MEM state
            OP_LW: begin
                dec.reg_write = 1'b1;
                dec.is_load   = 1'b1;
            end
            OP_SW:  dec.is_store = 1'b1;
            default: dec.reg_write = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// File: mips_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module mips_regfile import mips_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  reg_idx_t rs_idx,
    input  reg_idx_t rt_idx,
    output word_t    rs_val,
    output word_t    rt_val,
    input  logic     wr_en,
    input  reg_idx_t wr_idx,
    input  word_t    wr_data,
    output word_t    v0
);

    word_t regs [2**REG_ADDR_W];

    // Asynchronous read ports
    assign rs_val = regs[rs_idx];
    assign rt_val = regs[rt_idx];
    assign v0     = regs[REG_V0];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 2**REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_idx != '0) begin
            // Register 0 is never written so it reads as zero
            regs[wr_idx] <= wr_data;
        end
    end

endmodule

`default_nettype wire

// File: mips_alu.sv
`timescale 1ns/1ps
`default_nettype none

module mips_alu import mips_pkg::*; (
    input  alu_op_t    op,
    input  word_t      a,
    input  word_t      b,
    input  logic [4:0] shamt,
    output word_t      result
);

    logic lt_signed;
    logic lt_unsigned;

    // Compare results feed the set-on-less-than ops
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_AND:  result = a & b;
            ALU_OR:   result = a | b;
            ALU_XOR:  result = a ^ b;
            ALU_SLT:  result = {{(WORD_W-1){1'b0}}, lt_signed};
            ALU_SLTU: result = {{(WORD_W-1){1'b0}}, lt_unsigned};
            // Shifts act on the rt operand
            ALU_SLL:  result = b << shamt;
            ALU_SRL:  result = b >> shamt;
            ALU_SRA:  result = word_t'($signed(b) >>> shamt);
            // Immediate low half moves to the upper half
            ALU_LUI:  result = {b[15:0], 16'h0000};
            default:  result = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: mips_control.sv
`timescale 1ns/1ps
`default_nettype none

module mips_control import mips_pkg::*; #(
    parameter word_t RESET_VECTOR = 32'hBFC00000
) (
    input  logic     clk,
    input  logic     reset,
    input  decoded_t dec,
    input  word_t    rs_val,
    input  word_t    rt_val,
    input  word_t    alu_result,
    output word_t    instr,
    output logic     wr_en,
    output reg_idx_t wr_idx,
    output word_t    wr_data,
    output bus_req_t req,
    output logic     start,
    input  logic     done,
    input  word_t    rdata,
    output logic     active
);

    cpu_state_t state;
    word_t      pc;
    word_t      ir;
    word_t      jump_target;
    logic       delay;
    logic       fetch_sent;

    word_t pc_plus4;
    word_t next_pc;
    word_t branch_target;
    word_t mem_addr;
    word_t fetch_addr;
    logic  branch_taken;
    logic  is_mem;
    logic  launch_fetch;

    assign instr    = ir;
    assign pc_plus4 = pc + 32'd4;

    // Delay slot done, so move to the stored target
    assign next_pc = delay ? jump_target : pc_plus4;

    assign branch_target = pc_plus4 + {dec.imm[WORD_W-3:0], 2'b00};
    assign branch_taken  = (dec.is_beq && rs_val == rt_val) ||
                           (dec.is_bne && rs_val != rt_val);
    assign mem_addr      = rs_val + dec.imm;
    assign is_mem        = dec.is_load || dec.is_store;

    // EXEC fetches from the new pc, other states from the held pc
    assign fetch_addr   = (state == EXEC) ? next_pc : pc;
    assign launch_fetch = (state == FETCH && !fetch_sent) ||
                          (state == EXEC && !is_mem) ||
                          (state == MEM && done);

    // ALU results write in EXEC, loaded words when MEM finishes
    assign wr_en   = (state == EXEC && dec.reg_write && !dec.is_load) ||
                     (state == MEM && done && dec.is_load);
    assign wr_idx  = dec.dest;
    assign wr_data = (state == MEM) ? rdata : alu_result;

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= FETCH;
            pc         <= RESET_VECTOR;
            delay      <= 1'b0;
            fetch_sent <= 1'b0;
            start      <= 1'b0;
            active     <= 1'b1;
        end else begin
            start <= 1'b0;
            case (state)
                FETCH: begin
                    if (fetch_sent && done) begin
                        ir         <= rdata;
                        fetch_sent <= 1'b0;
                        state      <= EXEC;
                    end
                end
                EXEC: begin
                    pc    <= next_pc;
                    delay <= 1'b0;
                    // Any control transfer waits one instruction
                    if (branch_taken) begin
                        jump_target <= branch_target;
                        delay       <= 1'b1;
                    end else if (dec.is_j) begin
                        jump_target <= {pc_plus4[WORD_W-1:WORD_W-4], dec.jidx, 2'b00};
                        delay       <= 1'b1;
                    end else if (dec.is_jr) begin
                        jump_target <= rs_val;
                        delay       <= 1'b1;
                    end
                    if (is_mem) begin
                        req.addr  <= mem_addr;
                        req.wdata <= rt_val;
                        req.read  <= dec.is_load;
                        req.write <= dec.is_store;
                        start     <= 1'b1;
                        state     <= MEM;
                    end
                end
                MEM: begin
                    // Loaded word goes through the write port
                end
                default: begin
                    // HALTED holds until reset
                end
            endcase
            // Next fetch, or stop when it would come from zero
            if (launch_fetch) begin
                if (fetch_addr == HALT_ADDR) begin
                    state  <= HALTED;
                    active <= 1'b0;
                end else begin
                    req.addr   <= fetch_addr;
                    req.wdata  <= '0;
                    req.read   <= 1'b1;
                    req.write  <= 1'b0;
                    start      <= 1'b1;
                    fetch_sent <= 1'b1;
                    state      <= FETCH;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: mips_bus_master.sv
`timescale 1ns/1ps
`default_nettype none

module mips_bus_master import mips_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  bus_req_t   req,
    input  logic       start,
    output logic       done,
    output word_t      rdata,
    output word_t      address,
    output logic       read,
    output logic       write,
    output word_t      writedata,
    output logic [3:0] byteenable,
    input  logic       waitrequest,
    input  word_t      readdata
);

    bus_req_t req_q;
    logic     pending;
    logic     accept;

    // Avalon side comes straight from the held request
    assign address    = req_q.addr;
    assign writedata  = req_q.wdata;
    assign read       = pending && req_q.read;
    assign write      = pending && req_q.write;
    assign byteenable = 4'b1111;

    // Transfer completes when waitrequest is low
    assign accept = pending && !waitrequest;

    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= 1'b0;
            done    <= 1'b0;
        end else begin
            done <= accept;
            if (start) begin
                req_q   <= req;
                pending <= 1'b1;
            end else if (accept) begin
                pending <= 1'b0;
            end
            // Readdata is only valid in the accept cycle
            if (accept && req_q.read) begin
                rdata <= readdata;
            end
        end
    end

endmodule

`default_nettype wire

// File: mips_cpu_bus.sv
`timescale 1ns/1ps
`default_nettype none

module mips_cpu_bus import mips_pkg::*; #(
    parameter word_t RESET_VECTOR = 32'hBFC00000
) (
    input  logic       clk,
    input  logic       reset,
    output logic       active,
    output word_t      register_v0,
    output word_t      address,
    output logic       read,
    output logic       write,
    output word_t      writedata,
    output logic [3:0] byteenable,
    input  logic       waitrequest,
    input  word_t      readdata
);

    decoded_t dec;
    word_t    instr;
    word_t    rs_val;
    word_t    rt_val;
    word_t    alu_b;
    word_t    alu_result;
    logic     wr_en;
    reg_idx_t wr_idx;
    word_t    wr_data;
    bus_req_t req;
    logic     start;
    logic     done;
    word_t    rdata;

    // Second ALU operand is the immediate or rt
    assign alu_b = dec.use_imm ? dec.imm : rt_val;

    mips_decoder u_decoder (
        .instr (instr),
        .dec   (dec)
    );

    mips_regfile u_regfile (
        .clk     (clk),
        .reset   (reset),
        .rs_idx  (dec.rs),
        .rt_idx  (dec.rt),
        .rs_val  (rs_val),
        .rt_val  (rt_val),
        .wr_en   (wr_en),
        .wr_idx  (wr_idx),
        .wr_data (wr_data),
        .v0      (register_v0)
    );

    mips_alu u_alu (
        .op     (dec.alu_op),
        .a      (rs_val),
        .b      (alu_b),
        .shamt  (dec.shamt),
        .result (alu_result)
    );

    mips_control #(
        .RESET_VECTOR (RESET_VECTOR)
    ) u_control (
        .clk        (clk),
        .reset      (reset),
        .dec        (dec),
        .rs_val     (rs_val),
        .rt_val     (rt_val),
        .alu_result (alu_result),
        .instr      (instr),
        .wr_en      (wr_en),
        .wr_idx     (wr_idx),
        .wr_data    (wr_data),
        .req        (req),
        .start      (start),
        .done       (done),
        .rdata      (rdata),
        .active     (active)
    );

    mips_bus_master u_bus_master (
        .clk         (clk),
        .reset       (reset),
        .req         (req),
        .start       (start),
        .done        (done),
        .rdata       (rdata),
        .address     (address),
        .read        (read),
        .write       (write),
        .writedata   (writedata),
        .byteenable  (byteenable),
        .waitrequest (waitrequest),
        .readdata    (readdata)
    );

endmodule

`default_nettype wire

// File: mips_tb_mem.sv
`timescale 1ns/1ps
`default_nettype none

module mips_tb_mem import mips_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       stall_en,
    input  word_t      address,
    input  logic       read,
    input  logic       write,
    input  word_t      writedata,
    input  logic [3:0] byteenable,
    output logic       waitrequest,
    output word_t      readdata,
    output int         store_count,
    output bus_req_t   last_store,
    output logic [3:0] last_be
);

    word_t  mem [1024];
    integer seed;
    integer r;

    initial begin
        seed        = 32'hce8;
        waitrequest = 1'b0;
    end

    // Word addressed, low 4 KB only, data only while read is high
    assign readdata = read ? mem[address[11:2]] : 'x;

    // Back-pressure changes on the falling edge, like other inputs
    always @(negedge clk) begin
        r = $random(seed);
        waitrequest <= stall_en & r[0];
    end

    // Store monitor, writes land when the transfer is accepted
    always @(posedge clk) begin
        if (reset) begin
            store_count <= 0;
        end else if (write && !waitrequest) begin
            mem[address[11:2]] <= writedata;
            store_count        <= store_count + 1;
            last_store         <= '{addr: address, wdata: writedata, read: 1'b0, write: 1'b1};
            last_be            <= byteenable;
        end
    end

    // Pattern tied to the full byte address
    task automatic fill();
        for (int i = 0; i < 1024; i++) begin
            mem[i] = word_t'(i << 2) ^ 32'hA5A5_0000;
        end
    endtask

    task automatic load_word(input word_t addr, input word_t data);
        mem[addr[11:2]] = data;
    endtask

endmodule

`default_nettype wire

// File: mips_cpu_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module mips_cpu_asserts import mips_pkg::*; (
    input logic  clk,
    input logic  reset,
    input word_t address,
    input logic  read,
    input logic  write,
    input word_t writedata,
    input logic  waitrequest
);

    int fail_count = 0;

    // A stalled request keeps every field until it is accepted
    stalled_request_stable: assert property (@(posedge clk) disable iff (reset)
        (read || write) && waitrequest |=>
            $stable(address) && $stable(read) && $stable(write) && $stable(writedata))
        else begin
            fail_count++;
            $error("bus request changed while stalled");
        end

    read_write_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(read && write))
        else begin
            fail_count++;
            $error("read and write high together");
        end

    // One reset edge clears any pending transfer
    idle_during_reset: assert property (@(posedge clk) reset |=> !read && !write)
        else begin
            fail_count++;
            $error("bus request while in reset");
        end

endmodule

`default_nettype wire

// File: mips_cpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mips_cpu_tb import mips_pkg::*;;

    localparam word_t RV       = 32'h0000_0400;
    localparam int    NUM_ROWS = 13;
    localparam int    TIMEOUT  = 4000;

    logic       clk;
    logic       reset;
    logic       stall_en;
    logic       active;
    word_t      register_v0;
    word_t      address;
    logic       read;
    logic       write;
    word_t      writedata;
    logic [3:0] byteenable;
    logic       waitrequest;
    word_t      readdata;
    int         store_count;
    bus_req_t   last_store;
    logic [3:0] last_be;

    // Program table
    word_t    prog_tab [NUM_ROWS][8];
    word_t    exp_v0   [NUM_ROWS];
    bus_req_t exp_st   [NUM_ROWS];

    int value_errors;
    int timeout_errors;

    mips_cpu_bus #(.RESET_VECTOR(RV)) uut (
        .clk         (clk),
        .reset       (reset),
        .active      (active),
        .register_v0 (register_v0),
        .address     (address),
        .read        (read),
        .write       (write),
        .writedata   (writedata),
        .byteenable  (byteenable),
        .waitrequest (waitrequest),
        .readdata    (readdata)
    );

    mips_tb_mem mem_model (
        .clk         (clk),
        .reset       (reset),
        .stall_en    (stall_en),
        .address     (address),
        .read        (read),
        .write       (write),
        .writedata   (writedata),
        .byteenable  (byteenable),
        .waitrequest (waitrequest),
        .readdata    (readdata),
        .store_count (store_count),
        .last_store  (last_store),
        .last_be     (last_be)
    );

    bind mips_cpu_bus mips_cpu_asserts bus_rules (
        .clk         (clk),
        .reset       (reset),
        .address     (address),
        .read        (read),
        .write       (write),
        .writedata   (writedata),
        .waitrequest (waitrequest)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic word_t enc_r(funct_t fn, reg_idx_t rs, reg_idx_t rt, reg_idx_t rd,
                                    logic [4:0] sh);
        return {OP_RTYPE, rs, rt, rd, sh, fn};
    endfunction

    function automatic word_t enc_i(opcode_t op, reg_idx_t rs, reg_idx_t rt, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t enc_j(word_t target);
        return {OP_J, target[27:2]};
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_store(input string name, input bus_req_t got, input bus_req_t exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            value_errors++;
        end
    endtask

    task automatic build_table();
        word_t jr0;
        jr0 = enc_r(FN_JR, 0, 0, 0, 0);
        for (int r = 0; r < NUM_ROWS; r++) begin
            for (int k = 0; k < 8; k++) begin
                prog_tab[r][k] = '0;
            end
            exp_st[r] = '0;
        end
        // ADDIU with a negative immediate
        prog_tab[0][0:1] = '{enc_i(OP_ADDIU, 0, 2, 16'hFFFB), jr0};
        exp_v0[0] = 32'hFFFF_FFFB;
        prog_tab[1][0:2] = '{enc_i(OP_LUI, 0, 2, 16'h1234), enc_i(OP_ORI, 2, 2, 16'h5678), jr0};
        exp_v0[1] = 32'h1234_5678;
        // ANDI and XORI zero-extend
        prog_tab[2][0:4] = '{enc_i(OP_ADDIU, 0, 3, 16'hFFFF), enc_i(OP_ANDI, 3, 4, 16'h8000),
                             enc_i(OP_XORI, 0, 5, 16'h8001), enc_r(FN_ADDU, 4, 5, 2, 0), jr0};
        exp_v0[2] = 32'h0001_0001;
        prog_tab[3][0:4] = '{enc_i(OP_ADDIU, 0, 3, 16'd100), enc_i(OP_ADDIU, 0, 4, 16'd7),
                             enc_r(FN_SUBU, 3, 4, 5, 0), enc_r(FN_ADDU, 5, 3, 2, 0), jr0};
        exp_v0[3] = 32'd193;
        prog_tab[4][0:6] = '{enc_i(OP_LUI, 0, 3, 16'hFF00), enc_i(OP_ORI, 3, 3, 16'h0F0F),
                             enc_i(OP_ADDIU, 0, 4, 16'h0FF0), enc_r(FN_XOR, 3, 4, 5, 0),
                             enc_r(FN_AND, 3, 4, 6, 0), enc_r(FN_OR, 5, 6, 2, 0), jr0};
        exp_v0[4] = 32'hFF00_0FFF;
        // Signed -1 is less than 1, unsigned it is not
        prog_tab[5][0:6] = '{enc_i(OP_ADDIU, 0, 3, 16'hFFFF), enc_i(OP_ADDIU, 0, 4, 16'd1),
                             enc_r(FN_SLT, 3, 4, 5, 0), enc_r(FN_SLTU, 3, 4, 6, 0),
                             enc_r(FN_SLL, 0, 5, 5, 1), enc_r(FN_OR, 5, 6, 2, 0), jr0};
        exp_v0[5] = 32'd2;
        prog_tab[6][0:5] = '{enc_i(OP_ADDIU, 0, 3, 16'hFFFF), enc_i(OP_SLTI, 3, 5, 16'h0000),
                             enc_i(OP_SLTIU, 0, 6, 16'hFFFE), enc_r(FN_SLL, 0, 6, 6, 1),
                             enc_r(FN_ADDU, 5, 6, 2, 0), jr0};
        exp_v0[6] = 32'd3;
        prog_tab[7][0:5] = '{enc_i(OP_LUI, 0, 3, 16'h8000), enc_r(FN_SRA, 0, 3, 4, 4),
                             enc_r(FN_SRL, 0, 3, 5, 8), enc_r(FN_SLL, 0, 4, 6, 1),
                             enc_r(FN_XOR, 5, 6, 2, 0), jr0};
        exp_v0[7] = 32'hF080_0000;
        // Store then load back through the same address
        prog_tab[8][0:5] = '{enc_i(OP_ADDIU, 0, 3, 16'h0100), enc_i(OP_LUI, 0, 4, 16'hCAFE),
                             enc_i(OP_ORI, 4, 4, 16'hBABE), enc_i(OP_SW, 3, 4, 16'h0008),
                             enc_i(OP_LW, 3, 2, 16'h0008), jr0};
        exp_v0[8] = 32'hCAFE_BABE;
        exp_st[8] = '{addr: 32'h108, wdata: 32'hCAFE_BABE, read: 1'b0, write: 1'b1};
        // Taken BEQ, delay slot runs, next one skipped
        prog_tab[9][0:5] = '{enc_i(OP_ADDIU, 0, 3, 16'd5), enc_i(OP_BEQ, 3, 3, 16'd2),
                             enc_i(OP_ADDIU, 0, 2, 16'd1), enc_i(OP_ADDIU, 2, 2, 16'd16),
                             enc_i(OP_ADDIU, 2, 2, 16'h100), jr0};
        exp_v0[9] = 32'h101;
        // Untaken BNE falls through, then a taken one
        prog_tab[10][0:6] = '{enc_i(OP_BNE, 0, 0, 16'd2), enc_i(OP_ADDIU, 0, 2, 16'd1),
                              enc_i(OP_ADDIU, 2, 2, 16'd2), enc_i(OP_BNE, 2, 0, 16'd2),
                              enc_i(OP_ADDIU, 2, 2, 16'd4), enc_i(OP_ADDIU, 2, 2, 16'd8), jr0};
        exp_v0[10] = 32'd7;
        prog_tab[11][0:5] = '{enc_j(RV + 16), enc_i(OP_ADDIU, 0, 2, 16'd3),
                              enc_i(OP_ADDIU, 2, 2, 16'd16), enc_i(OP_ADDIU, 2, 2, 16'd32),
                              enc_i(OP_ADDIU, 2, 2, 16'd64), jr0};
        exp_v0[11] = 32'h43;
        prog_tab[12][0:6] = '{enc_i(OP_ADDIU, 0, 3, 16'h0414), enc_r(FN_JR, 3, 0, 0, 0),
                              enc_i(OP_ADDIU, 0, 2, 16'd9), enc_i(OP_ADDIU, 2, 2, 16'd16),
                              enc_i(OP_ADDIU, 2, 2, 16'd32), enc_i(OP_ADDIU, 2, 2, 16'h100),
                              jr0};
        exp_v0[12] = 32'h109;
    endtask

    task automatic run_row(input int r);
        int cycles;
        int late_requests;
        reset = 1'b1;
        mem_model.fill();
        for (int k = 0; k < 8; k++) begin
            mem_model.load_word(RV + 4 * k, prog_tab[r][k]);
        end
        repeat (8) @(negedge clk);
        check_word("read", word_t'(read), '0);
        check_word("write", word_t'(write), '0);
        reset = 1'b0;
        check_word("active", word_t'(active), 32'd1);
        // First fetch must come from the reset vector
        cycles = 0;
        while (!read && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!read) begin
            $display("Row %0d timed out waiting for the first fetch", r);
            timeout_errors++;
        end
        check_word("address", address, RV);
        cycles = 0;
        while (active && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (active) begin
            $display("Row %0d timed out waiting for the processor to halt", r);
            timeout_errors++;
        end
        // Bus stays quiet once halted
        late_requests = 0;
        repeat (20) begin
            @(negedge clk);
            if (read || write) begin
                late_requests++;
            end
        end
        check_word("late_requests", word_t'(late_requests), '0);
        check_word("register_v0", register_v0, exp_v0[r]);
        if (exp_st[r].write) begin
            check_word("store_count", word_t'(store_count), 32'd1);
            check_store("last_store", last_store, exp_st[r]);
            check_word("byteenable", word_t'(last_be), 32'hF);
        end else begin
            check_word("store_count", word_t'(store_count), '0);
        end
    endtask

    initial begin
        reset          = 1'b1;
        stall_en       = 1'b0;
        value_errors   = 0;
        timeout_errors = 0;
        build_table();
        @(negedge clk);
        // Pass 0 without back-pressure, pass 1 with random stalls
        for (int pass = 0; pass < 2; pass++) begin
            stall_en = (pass == 1);
            for (int r = 0; r < NUM_ROWS; r++) begin
                run_row(r);
            end
        end
        $display("Value errors: %0d, timeouts: %0d, assertion failures: %0d",
                 value_errors, timeout_errors, uut.bus_rules.fail_count);
        if (value_errors == 0 && timeout_errors == 0 && uut.bus_rules.fail_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
mips_pkg.sv
mips_decoder.sv
mips_regfile.sv
mips_alu.sv
mips_control.sv
mips_bus_master.sv
mips_cpu_bus.sv
mips_tb_mem.sv
mips_cpu_asserts.sv
mips_cpu_tb.sv

// File: Bender.yml
package:
  name: mips_cpu_bus

sources:
  - mips_pkg.sv
  - mips_decoder.sv
  - mips_regfile.sv
  - mips_alu.sv
  - mips_control.sv
  - mips_bus_master.sv
  - mips_cpu_bus.sv
  - target: test
    files:
      - mips_tb_mem.sv
      - mips_cpu_asserts.sv
      - mips_cpu_tb.sv
